/* hdl/mips_macros.svh */
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

`define SEQ_WIDTH 16
`define CNT_WIDTH 16

`define ERET_WORD 32'h4200_0018

`define OP_SPECIAL  6'b000000
`define OP_REGIMM   6'b000001
`define OP_J        6'b000010
`define OP_JAL      6'b000011
`define OP_BEQ      6'b000100
`define OP_BNE      6'b000101
`define OP_BLEZ     6'b000110
`define OP_BGTZ     6'b000111
`define OP_ADDI     6'b001000
`define OP_ADDIU    6'b001001
`define OP_SLTI     6'b001010
`define OP_SLTIU    6'b001011
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_XORI     6'b001110
`define OP_LUI      6'b001111
`define OP_COP0     6'b010000
`define OP_SPECIAL2 6'b011100
`define OP_SPECIAL3 6'b011111
`define OP_LB       6'b100000
`define OP_LH       6'b100001
`define OP_LWL      6'b100010
`define OP_LW       6'b100011
`define OP_LBU      6'b100100
`define OP_LHU      6'b100101
`define OP_LWR      6'b100110
`define OP_SB       6'b101000
`define OP_SH       6'b101001
`define OP_SWL      6'b101010
`define OP_SW       6'b101011
`define OP_SWR      6'b101110
`define OP_LL       6'b110000

`define FN_SLL     6'b000000
`define FN_SRL     6'b000010
`define FN_SRA     6'b000011
`define FN_SLLV    6'b000100
`define FN_SRLV    6'b000110
`define FN_SRAV    6'b000111
`define FN_JR      6'b001000
`define FN_JALR    6'b001001
`define FN_MOVZ    6'b001010
`define FN_MOVN    6'b001011
`define FN_SYSCALL 6'b001100
`define FN_BREAK   6'b001101
`define FN_MFHI    6'b010000
`define FN_MTHI    6'b010001
`define FN_MFLO    6'b010010
`define FN_MTLO    6'b010011
`define FN_MULT    6'b011000
`define FN_MULTU   6'b011001
`define FN_DIV     6'b011010
`define FN_DIVU    6'b011011
`define FN_ADD     6'b100000
`define FN_ADDU    6'b100001
`define FN_SUB     6'b100010
`define FN_SUBU    6'b100011
`define FN_AND     6'b100100
`define FN_OR      6'b100101
`define FN_XOR     6'b100110
`define FN_NOR     6'b100111
`define FN_SLT     6'b101010
`define FN_SLTU    6'b101011

`define RT_BLTZ   5'b00000
`define RT_BGEZ   5'b00001
`define RT_BLTZAL 5'b10000
`define RT_BGEZAL 5'b10001

`define RS_MFC0 5'b00000
`define RS_MTC0 5'b00100

`define F2_MADD  6'b000000
`define F2_MADDU 6'b000001
`define F2_MUL   6'b000010
`define F2_MSUB  6'b000100
`define F2_MSUBU 6'b000101
`define F2_CLZ   6'b100000
`define F2_CLO   6'b100001

`define F3_EXT   6'b000000
`define F3_INS   6'b000100
`define F3_BSHFL 6'b100000

`define SH_WSBH 5'b00010
`define SH_SEB  5'b10000
`define SH_SEH  5'b11000

`endif

/* hdl/mipsPkg.sv */
package mipsPkg;

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFields;

	typedef struct packed {
		logic [5:0]  op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} iFields;

	typedef struct packed {
		logic [5:0]  op;
		logic [25:0] target;
	} jFields;

	// one retired word seen through each of the three MIPS formats.
	typedef union packed {
		rFields r;
		iFields i;
		jFields j;
	} instrWord;

endpackage

/* hdl/retireCapture.sv */
`timescale 1ns/1ps
`include "mips_macros.svh"

module retireCapture (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  retireValid,
	input  logic [31:0]           retirePc,
	input  logic [31:0]           retireInstr,
	output logic                  capValid,
	output logic [31:0]           capPc,
	output mipsPkg::instrWord     capInstr,
	output logic [`SEQ_WIDTH-1:0] capSeq
);

	logic [`SEQ_WIDTH-1:0] seqCnt; // number handed to the next retirement.

	always_ff @(posedge clk) begin
		if (reset) begin
			capValid <= 1'b0;
			seqCnt   <= '0;
		end else begin
			capValid <= retireValid;
			if (retireValid) begin
				seqCnt <= seqCnt + 1'b1; // wraps at the counter width.
			end
		end
	end

	always_ff @(posedge clk) begin
		if (retireValid) begin
			capPc    <= retirePc;
			capInstr <= retireInstr;
			capSeq   <= seqCnt;
		end
	end

	pcAligned: assert property (
		@(posedge clk) disable iff (reset)
		retireValid |-> (retirePc[1:0] == 2'b00)
	);

endmodule

/* hdl/instDecode.sv */
`timescale 1ns/1ps
`include "mips_macros.svh"

module instDecode (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  capValid,
	input  logic [31:0]           capPc,
	input  mipsPkg::instrWord     capInstr,
	input  logic [`SEQ_WIDTH-1:0] capSeq,
	output logic                  decValid,
	output logic [31:0]           decPc,
	output logic [31:0]           decInstr,
	output logic [`SEQ_WIDTH-1:0] decSeq,
	output logic [47:0]           decAscii,
	output logic                  decUnknown
);

	logic [47:0] ascii;
	logic        unknown;

	always_comb begin
		ascii = "N-R";
		case (capInstr.r.op)
			`OP_SPECIAL: begin
				case (capInstr.r.funct)
					`FN_SLL:     ascii = "SLL";
					`FN_SRL:     ascii = "SRL";
					`FN_SRA:     ascii = "SRA";
					`FN_SLLV:    ascii = "SLLV";
					`FN_SRLV:    ascii = "SRLV";
					`FN_SRAV:    ascii = "SRAV";
					`FN_JR:      ascii = "JR";
					`FN_JALR:    ascii = "JALR";
					`FN_MOVZ:    ascii = "MOVZ";
					`FN_MOVN:    ascii = "MOVN";
					`FN_SYSCALL: ascii = "SYSC";
					`FN_BREAK:   ascii = "BREAK";
					`FN_MFHI:    ascii = "MFHI";
					`FN_MTHI:    ascii = "MTHI";
					`FN_MFLO:    ascii = "MFLO";
					`FN_MTLO:    ascii = "MTLO";
					`FN_MULT:    ascii = "MULT";
					`FN_MULTU:   ascii = "MULTU";
					`FN_DIV:     ascii = "DIV";
					`FN_DIVU:    ascii = "DIVU";
					`FN_ADD:     ascii = "ADD";
					`FN_ADDU:    ascii = "ADDU";
					`FN_SUB:     ascii = "SUB";
					`FN_SUBU:    ascii = "SUBU";
					`FN_AND:     ascii = "AND";
					`FN_OR:      ascii = "OR";
					`FN_XOR:     ascii = "XOR";
					`FN_NOR:     ascii = "NOR";
					`FN_SLT:     ascii = "SLT";
					`FN_SLTU:    ascii = "SLTU";
					default:     ascii = "N-R";
				endcase
			end
			`OP_REGIMM: begin
				case (capInstr.i.rt) // branch kind lives in the rt slot.
					`RT_BLTZ:   ascii = "BLTZ";
					`RT_BGEZ:   ascii = "BGEZ";
					`RT_BLTZAL: ascii = "BLTZAL";
					`RT_BGEZAL: ascii = "BGEZAL";
					default:    ascii = "N-R";
				endcase
			end
			`OP_J:     ascii = "J";
			`OP_JAL:   ascii = "JAL";
			`OP_BEQ:   ascii = "BEQ";
			`OP_BNE:   ascii = "BNE";
			`OP_BLEZ:  ascii = "BLEZ";
			`OP_BGTZ:  ascii = "BGTZ";
			`OP_ADDI:  ascii = "ADDI";
			`OP_ADDIU: ascii = "ADDIU";
			`OP_SLTI:  ascii = "SLTI";
			`OP_SLTIU: ascii = "SLTIU";
			`OP_ANDI:  ascii = "ANDI";
			`OP_ORI:   ascii = "ORI";
			`OP_XORI:  ascii = "XORI";
			`OP_LUI:   ascii = "LUI";
			`OP_COP0: begin
				case (capInstr.r.rs)
					`RS_MFC0: ascii = "MFC0";
					`RS_MTC0: ascii = "MTC0";
					default:  ascii = "N-R"; // ERET is caught as a whole word below.
				endcase
			end
			`OP_SPECIAL2: begin
				case (capInstr.r.funct)
					`F2_MADD:  ascii = "MADD";
					`F2_MADDU: ascii = "MADDU";
					`F2_MUL:   ascii = "MUL";
					`F2_MSUB:  ascii = "MSUB";
					`F2_MSUBU: ascii = "MSUBU";
					`F2_CLZ:   ascii = "CLZ";
					`F2_CLO:   ascii = "CLO";
					default:   ascii = "N-R";
				endcase
			end
			`OP_SPECIAL3: begin
				case (capInstr.r.funct)
					`F3_EXT: ascii = "EXT";
					`F3_INS: ascii = "INS";
					`F3_BSHFL: begin
						case (capInstr.r.shamt) // BSHFL picks its operation by shamt.
							`SH_WSBH: ascii = "WSBH";
							`SH_SEB:  ascii = "SEB";
							`SH_SEH:  ascii = "SEH";
							default:  ascii = "N-R";
						endcase
					end
					default: ascii = "N-R";
				endcase
			end
			`OP_LB:  ascii = "LB";
			`OP_LH:  ascii = "LH";
			`OP_LWL: ascii = "LWL";
			`OP_LW:  ascii = "LW";
			`OP_LBU: ascii = "LBU";
			`OP_LHU: ascii = "LHU";
			`OP_LWR: ascii = "LWR";
			`OP_SB:  ascii = "SB";
			`OP_SH:  ascii = "SH";
			`OP_SWL: ascii = "SWL";
			`OP_SW:  ascii = "SW";
			`OP_SWR: ascii = "SWR";
			`OP_LL:  ascii = "LL";
			default: ascii = "N-R";
		endcase
		if (capInstr == `ERET_WORD) begin
			ascii = "ERET";
		end
		if (capInstr == 32'd0) begin
			ascii = "NOP"; // the zero word would otherwise read as SLL.
		end
	end

	assign unknown = (ascii == "N-R");

	always_ff @(posedge clk) begin
		if (reset) begin
			decValid   <= 1'b0;
			decUnknown <= 1'b0;
		end else begin
			decValid   <= capValid;
			decUnknown <= capValid && unknown; // low on idle cycles.
		end
	end

	always_ff @(posedge clk) begin
		if (capValid) begin
			decPc    <= capPc;
			decInstr <= capInstr;
			decSeq   <= capSeq;
			decAscii <= ascii;
		end
	end

	asciiPresent: assert property (
		@(posedge clk) disable iff (reset)
		decValid |-> (decAscii != 48'd0)
	);

endmodule

/* hdl/traceStats.sv */
`timescale 1ns/1ps
`include "mips_macros.svh"

module traceStats (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  decValid,
	input  logic [31:0]           decPc,
	input  logic [31:0]           decInstr,
	input  logic [`SEQ_WIDTH-1:0] decSeq,
	input  logic [47:0]           decAscii,
	input  logic                  decUnknown,
	output logic                  traceValid,
	output logic [31:0]           tracePc,
	output logic [31:0]           traceInstr,
	output logic [47:0]           traceAscii,
	output logic [`SEQ_WIDTH-1:0] traceSeq,
	output logic                  traceUnknown,
	output logic [`CNT_WIDTH-1:0] unknownCount
);

	always_ff @(posedge clk) begin
		if (reset) begin
			traceValid   <= 1'b0;
			traceUnknown <= 1'b0;
			unknownCount <= '0;
		end else begin
			traceValid   <= decValid;
			traceUnknown <= decUnknown;
			if (decValid && decUnknown && (unknownCount != '1)) begin
				unknownCount <= unknownCount + 1'b1; // holds once it hits the top.
			end
		end
	end

	always_ff @(posedge clk) begin
		if (decValid) begin
			tracePc    <= decPc;
			traceInstr <= decInstr;
			traceAscii <= decAscii;
			traceSeq   <= decSeq;
		end
	end

	unknownOnlyWithRecord: assert property (
		@(posedge clk) disable iff (reset)
		traceUnknown |-> traceValid
	);

endmodule

/* hdl/instTrace.sv */
`timescale 1ns/1ps
`include "mips_macros.svh"

module instTrace (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  retireValid,
	input  logic [31:0]           retirePc,
	input  logic [31:0]           retireInstr,
	output logic                  traceValid,
	output logic [31:0]           tracePc,
	output logic [31:0]           traceInstr,
	output logic [47:0]           traceAscii,
	output logic [`SEQ_WIDTH-1:0] traceSeq,
	output logic                  traceUnknown,
	output logic [`CNT_WIDTH-1:0] unknownCount
);

	logic                  capValid;
	logic [31:0]           capPc;
	mipsPkg::instrWord     capInstr;
	logic [`SEQ_WIDTH-1:0] capSeq;

	logic                  decValid;
	logic [31:0]           decPc;
	logic [31:0]           decInstr;
	logic [`SEQ_WIDTH-1:0] decSeq;
	logic [47:0]           decAscii;
	logic                  decUnknown;

	retireCapture capture (
		.clk         (clk),
		.reset       (reset),
		.retireValid (retireValid),
		.retirePc    (retirePc),
		.retireInstr (retireInstr),
		.capValid    (capValid),
		.capPc       (capPc),
		.capInstr    (capInstr),
		.capSeq      (capSeq)
	);

	instDecode decode (
		.clk        (clk),
		.reset      (reset),
		.capValid   (capValid),
		.capPc      (capPc),
		.capInstr   (capInstr),
		.capSeq     (capSeq),
		.decValid   (decValid),
		.decPc      (decPc),
		.decInstr   (decInstr),
		.decSeq     (decSeq),
		.decAscii   (decAscii),
		.decUnknown (decUnknown)
	);

	traceStats stats (
		.clk          (clk),
		.reset        (reset),
		.decValid     (decValid),
		.decPc        (decPc),
		.decInstr     (decInstr),
		.decSeq       (decSeq),
		.decAscii     (decAscii),
		.decUnknown   (decUnknown),
		.traceValid   (traceValid),
		.tracePc      (tracePc),
		.traceInstr   (traceInstr),
		.traceAscii   (traceAscii),
		.traceSeq     (traceSeq),
		.traceUnknown (traceUnknown),
		.unknownCount (unknownCount)
	);

endmodule

/* dv/instTraceTb.sv */
`timescale 1ns/1ps
`include "mips_macros.svh"

module instTraceTb;

	logic                  clk;
	logic                  reset;
	logic                  retireValid;
	logic [31:0]           retirePc;
	logic [31:0]           retireInstr;
	logic                  traceValid;
	logic [31:0]           tracePc;
	logic [31:0]           traceInstr;
	logic [47:0]           traceAscii;
	logic [`SEQ_WIDTH-1:0] traceSeq;
	logic                  traceUnknown;
	logic [`CNT_WIDTH-1:0] unknownCount;

	logic [31:0] instrTab [$];
	logic [47:0] asciiTab [$];
	int          strobeCycles [$];
	int          nrTotal = 0;
	int          expUnknown = 0;
	int          recCount = 0;
	int          cycleCnt = 0;
	int          mismatchCount = 0;
	int          otherErrors = 0;
	int          idle;
	int          waitCnt;
	logic [31:0] rng = 32'd97644;

	instTrace dut (
		.clk          (clk),
		.reset        (reset),
		.retireValid  (retireValid),
		.retirePc     (retirePc),
		.retireInstr  (retireInstr),
		.traceValid   (traceValid),
		.tracePc      (tracePc),
		.traceInstr   (traceInstr),
		.traceAscii   (traceAscii),
		.traceSeq     (traceSeq),
		.traceUnknown (traceUnknown),
		.unknownCount (unknownCount)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCnt <= cycleCnt + 1;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			mismatchCount++;
			$display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic addEntry(input logic [31:0] instr, input logic [47:0] ascii);
		instrTab.push_back(instr);
		asciiTab.push_back(ascii);
		if (ascii == "N-R") begin
			nrTotal++;
		end
	endtask

	task automatic buildTable();
		addEntry(32'h012A_4020, "ADD");
		addEntry(32'h0000_000C, "SYSC");
		addEntry(32'h03E0_0008, "JR");
		addEntry(32'h0009_4080, "SLL");
		addEntry(32'h0000_0001, "N-R");
		addEntry(32'h0000_003F, "N-R");
		addEntry(32'h0000_0005, "N-R");
		addEntry(32'h0501_0004, "BGEZ");
		addEntry(32'h0510_0004, "BLTZAL");
		addEntry(32'h0502_0004, "N-R");
		addEntry(32'h051F_0004, "N-R");
		addEntry(32'h0810_0000, "J");
		addEntry(32'h0C10_0000, "JAL");
		addEntry(32'h1109_0003, "BEQ");
		addEntry(32'h2408_0001, "ADDIU");
		addEntry(32'h3C08_1234, "LUI");
		addEntry(32'h8FA8_0000, "LW");
		addEntry(32'hAFA8_0004, "SW");
		addEntry(32'hFC00_0000, "N-R");
		addEntry(32'h4400_0000, "N-R");
		addEntry(32'hBC00_0000, "N-R");
		addEntry(32'h4008_6000, "MFC0");
		addEntry(32'h4088_6000, "MTC0");
		addEntry(32'h4028_6000, "N-R");
		addEntry(32'h4200_0020, "N-R");  // WAIT shares the CO space with ERET.
		addEntry(`ERET_WORD, "ERET");
		addEntry(32'h712A_4002, "MUL");
		addEntry(32'h7120_4020, "CLZ");
		addEntry(32'h7000_003F, "N-R");
		addEntry(32'h7000_0003, "N-R");
		addEntry(32'h7C00_0000, "EXT");
		addEntry(32'h7C00_0004, "INS");
		addEntry(32'h7C00_0420, "SEB");
		addEntry(32'h7C00_00A0, "WSBH");
		addEntry(32'h7C00_0620, "SEH");
		addEntry(32'h7C00_0060, "N-R");
		addEntry(32'h7C00_003B, "N-R");
		addEntry(32'h0000_0000, "NOP");
	endtask

	// compares one trace record against the table entry with the same index.
	task automatic checkRecord();
		int          lat;
		logic [47:0] expAscii;
		expAscii = asciiTab[recCount];
		if (expAscii == "N-R") begin
			expUnknown++;
		end
		lat = cycleCnt - strobeCycles.pop_front();
		checkValue("tracePc", tracePc, 32'h0040_0000 + 32'(4 * recCount));
		checkValue("traceInstr", traceInstr, instrTab[recCount]);
		checkValue("traceAscii", traceAscii, expAscii);
		checkValue("traceSeq", traceSeq, `SEQ_WIDTH'(recCount));
		checkValue("traceUnknown", traceUnknown, expAscii == "N-R");
		checkValue("unknownCount", unknownCount, expUnknown);
		checkValue("latency", lat, 3);
		recCount++;
	endtask

	// sampled on the falling edge, where every output has settled.
	always @(negedge clk) begin
		if (!reset) begin
			if (retireValid) begin
				strobeCycles.push_back(cycleCnt); // the edge that drove it.
			end
			if (traceValid) begin
				if (recCount >= instrTab.size() || strobeCycles.size() == 0) begin
					otherErrors++;
					$display("trace record at %0t has no matching retirement", $time);
				end else begin
					checkRecord();
				end
			end
		end
	end

	initial begin
		reset       = 1'b1;
		retireValid = 1'b0;
		retirePc    = '0;
		retireInstr = '0;
		buildTable();
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		checkValue("traceValid", traceValid, 0);
		checkValue("unknownCount", unknownCount, 0);

		for (int i = 0; i < instrTab.size(); i++) begin
			@(posedge clk);
			retireValid <= 1'b1;
			retirePc    <= 32'h0040_0000 + 32'(4 * i);
			retireInstr <= instrTab[i];
			rng = xorshift(rng);
			idle = rng[2] ? 0 : int'(rng[1:0]); // about half the strobes run back to back.
			if (idle != 0) begin
				@(posedge clk);
				retireValid <= 1'b0;
				repeat (idle - 1) @(posedge clk);
			end
		end
		@(posedge clk);
		retireValid <= 1'b0;

		for (waitCnt = 0; waitCnt < 20 && recCount < instrTab.size(); waitCnt++) begin
			@(negedge clk);
		end
		if (recCount != instrTab.size()) begin
			otherErrors++;
			$display("timed out with %0d of %0d trace records seen", recCount, instrTab.size());
		end
		checkValue("unknownCount", unknownCount, nrTotal);

		$display("errors: %0d mismatches, %0d other failures", mismatchCount, otherErrors);
		if (mismatchCount == 0 && otherErrors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

/* compile.f */
+incdir+hdl
hdl/mipsPkg.sv
hdl/retireCapture.sv
hdl/instDecode.sv
hdl/traceStats.sv
hdl/instTrace.sv
dv/instTraceTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the trace monitor testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module instTraceTb -f compile.f \
	--Mdir obj_dir -o instTraceSim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/instTraceSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "test passed" sim.log; then
	exit 0
fi
exit 1
